// File: src/spmd_loader_pkg.sv
package spmd_loader_pkg;

  // ------------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------------
  localparam int data_width_c      = 32;  // store payload
  localparam int addr_width_c      = 16;  // tile word address
  localparam int x_cord_width_c    = 3;
  localparam int y_cord_width_c    = 3;
  localparam int host_addr_width_c = 8;   // host register / image address
  localparam int word_cnt_width_c  = 8;   // per-tile word counts

  // ------------------------------------------------------------------------
  // tile address map, all word addresses
  // ------------------------------------------------------------------------
  localparam logic [addr_width_c-1:0] csr_base_addr_c   =
    addr_width_c'(1) << (addr_width_c - 1);        // top bit marks the CSR window
  localparam logic [addr_width_c-1:0] icache_sel_addr_c =
    addr_width_c'(1) << 14;                        // bit 14 steers into the icache
  localparam logic [addr_width_c-1:0] unfreeze_addr_c   = csr_base_addr_c;
  localparam logic [addr_width_c-1:0] csr_org_x_offs_c  = addr_width_c'(1);
  localparam logic [addr_width_c-1:0] csr_org_y_offs_c  = addr_width_c'(2);

  // host register map
  localparam logic [host_addr_width_c-1:0] reg_org_x_c        = 8'd0;
  localparam logic [host_addr_width_c-1:0] reg_org_y_c        = 8'd1;
  localparam logic [host_addr_width_c-1:0] reg_dim_x_c        = 8'd2;
  localparam logic [host_addr_width_c-1:0] reg_dim_y_c        = 8'd3;
  localparam logic [host_addr_width_c-1:0] reg_icache_words_c = 8'd4;
  localparam logic [host_addr_width_c-1:0] reg_dmem_words_c   = 8'd5;
  localparam logic [host_addr_width_c-1:0] reg_dmem_base_c    = 8'd6;
  localparam logic [host_addr_width_c-1:0] reg_start_c        = 8'd7;

  // ------------------------------------------------------------------------
  // types
  // ------------------------------------------------------------------------
  typedef enum logic [1:0] {
    e_packet_op_remote_load  = 2'd0,
    e_packet_op_remote_store = 2'd1,  // the only op the loader sends
    e_packet_op_remote_amo   = 2'd2,
    e_packet_op_reserved     = 2'd3
  } packet_op_e;

  typedef struct packed {
    packet_op_e                op;
    logic [addr_width_c-1:0]   addr;
    logic [data_width_c-1:0]   payload;
    logic [x_cord_width_c-1:0] x_cord;
    logic [y_cord_width_c-1:0] y_cord;
    logic [x_cord_width_c-1:0] src_x_cord;
    logic [y_cord_width_c-1:0] src_y_cord;
  } load_packet_s;

  typedef enum logic [2:0] {
    e_phase_idle      = 3'd0,
    e_phase_group_cfg = 3'd1,
    e_phase_icache    = 3'd2,
    e_phase_dmem      = 3'd3,
    e_phase_unfreeze  = 3'd4
  } load_phase_e;

  typedef struct packed {
    logic                         to_image;  // 1: image word, 0: load register
    logic [host_addr_width_c-1:0] addr;
    logic [data_width_c-1:0]      data;
  } host_wr_s;

  typedef struct packed {
    logic [x_cord_width_c-1:0]   org_x;
    logic [y_cord_width_c-1:0]   org_y;
    logic [x_cord_width_c-1:0]   dim_x;
    logic [y_cord_width_c-1:0]   dim_y;
    logic [word_cnt_width_c-1:0] icache_words;
    logic [word_cnt_width_c-1:0] dmem_words;
    logic [word_cnt_width_c-1:0] dmem_base;   // image index of dmem word 0
  } load_cfg_s;

endpackage

// File: src/loader_cfg_regs.sv
`timescale 1ns/10ps

module loader_cfg_regs
  import spmd_loader_pkg::*;
#(
  parameter int image_depth_p = 64
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             host_wr_v_i,
  input  host_wr_s                         host_wr_i,
  input  logic                             busy_i,
  output load_cfg_s                        cfg_o,
  output logic                             start_o,
  output logic                             img_we_o,
  output logic [$clog2(image_depth_p)-1:0] img_waddr_o,
  output logic [data_width_c-1:0]          img_wdata_o
);

  localparam int img_aw_lp = $clog2(image_depth_p);

  load_cfg_s cfg_q;
  logic      start_q;
  logic      wr_accept;
  logic      reg_wr;

  // a start still in flight locks the port just like busy does
  assign wr_accept = host_wr_v_i && !busy_i && !start_q;
  assign reg_wr    = wr_accept && !host_wr_i.to_image;

  // image writes pass straight through to the memory port
  assign img_we_o    = wr_accept && host_wr_i.to_image;
  assign img_waddr_o = img_aw_lp'(host_wr_i.addr);
  assign img_wdata_o = host_wr_i.data;

  // ------------------------------------------------------------------------
  // load registers and start strobe
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q   <= '0;
      start_q <= 1'b0;
    end else begin
      start_q <= reg_wr && (host_wr_i.addr == reg_start_c);  // one cycle only
      if (reg_wr) begin
        case (host_wr_i.addr)
          reg_org_x_c:        cfg_q.org_x        <= host_wr_i.data[x_cord_width_c-1:0];
          reg_org_y_c:        cfg_q.org_y        <= host_wr_i.data[y_cord_width_c-1:0];
          reg_dim_x_c:        cfg_q.dim_x        <= host_wr_i.data[x_cord_width_c-1:0];
          reg_dim_y_c:        cfg_q.dim_y        <= host_wr_i.data[y_cord_width_c-1:0];
          reg_icache_words_c: cfg_q.icache_words <= host_wr_i.data[word_cnt_width_c-1:0];
          reg_dmem_words_c:   cfg_q.dmem_words   <= host_wr_i.data[word_cnt_width_c-1:0];
          reg_dmem_base_c:    cfg_q.dmem_base    <= host_wr_i.data[word_cnt_width_c-1:0];
          default: ;  // start and unmapped addresses
        endcase
      end
    end
  end

  assign cfg_o   = cfg_q;
  assign start_o = start_q;

  // the sequencer raises busy one cycle after start, so the two never overlap
  a_no_start_while_busy: assert property (
    @(posedge clk_i) disable iff (reset_i)
    start_o |-> !busy_i
  ) else $error("start strobe raised while the loader is busy");

endmodule

// File: src/program_image_mem.sv
`timescale 1ns/10ps

module program_image_mem
  import spmd_loader_pkg::*;
#(
  parameter int image_depth_p = 64
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             we_i,
  input  logic [$clog2(image_depth_p)-1:0] waddr_i,
  input  logic [data_width_c-1:0]          wdata_i,
  input  logic                             re_i,
  input  logic [$clog2(image_depth_p)-1:0] raddr_i,
  output logic [data_width_c-1:0]          rdata_o
);

  logic [data_width_c-1:0] mem_q [image_depth_p];
  logic [data_width_c-1:0] rdata_q;

  // image words, cleared on reset so unwritten words read back as zero
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < image_depth_p; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // read register only moves on re_i, a stalled reader keeps its word
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_q <= '0;
    end else if (re_i) begin
      rdata_q <= mem_q[raddr_i];  // old data on a same-cycle write
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: src/spmd_loader_seq.sv
`timescale 1ns/10ps

module spmd_loader_seq
  import spmd_loader_pkg::*;
#(
  parameter int image_depth_p = 64
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             start_i,
  input  load_cfg_s                        cfg_i,
  input  logic [x_cord_width_c-1:0]        my_x_i,
  input  logic [y_cord_width_c-1:0]        my_y_i,
  output logic                             img_re_o,
  output logic [$clog2(image_depth_p)-1:0] img_raddr_o,
  input  logic [data_width_c-1:0]          img_rdata_i,
  output load_packet_s                     packet_o,
  output logic                             v_o,
  input  logic                             ready_i,
  output logic                             busy_o,
  output logic                             done_o
);

  localparam int img_aw_lp = $clog2(image_depth_p);

  typedef struct packed {
    load_phase_e                 phase;
    logic [x_cord_width_c-1:0]   tx;     // tile offset from origin
    logic [y_cord_width_c-1:0]   ty;
    logic [word_cnt_width_c-1:0] w;      // word within the tile
  } walk_pos_s;

  typedef struct packed {
    load_packet_s pkt;
    logic         use_img;  // payload is taken from the image read
  } fetch_entry_s;

  // next phase that has work, empty phases are skipped
  function automatic load_phase_e phase_after(load_phase_e p, load_cfg_s c);
    load_phase_e n;
    n = e_phase_idle;
    if (c.dim_x != '0 && c.dim_y != '0) begin
      case (p)
        e_phase_idle:      n = e_phase_group_cfg;
        e_phase_group_cfg: n = (c.icache_words != '0) ? e_phase_icache :
                               (c.dmem_words != '0)   ? e_phase_dmem   : e_phase_unfreeze;
        e_phase_icache:    n = (c.dmem_words != '0) ? e_phase_dmem : e_phase_unfreeze;
        e_phase_dmem:      n = e_phase_unfreeze;
        default:           n = e_phase_idle;
      endcase
    end
    return n;
  endfunction

  walk_pos_s                   pos_q, pos_nxt, cur;
  load_cfg_s                   cfg_q, cur_cfg;
  fetch_entry_s                fetch_q, fetch_nxt;
  load_packet_s                out_q, out_nxt;
  logic                        fetch_v_q, v_q, busy_q, done_q;
  logic                        cur_active, pipe_adv, done_set;
  logic                        w_last, x_last, y_last;
  logic [word_cnt_width_c-1:0] phase_words;

  // ------------------------------------------------------------------------
  // walker, the start cycle already presents the first item
  // ------------------------------------------------------------------------
  always_comb begin
    if (start_i) begin
      cur_cfg = cfg_i;
      cur     = '{phase: phase_after(e_phase_idle, cfg_i), tx: '0, ty: '0, w: '0};
    end else begin
      cur_cfg = cfg_q;
      cur     = pos_q;
    end
  end

  assign cur_active = (cur.phase != e_phase_idle);

  always_comb begin
    case (cur.phase)
      e_phase_group_cfg: phase_words = word_cnt_width_c'(2);  // org_x then org_y
      e_phase_icache:    phase_words = cur_cfg.icache_words;
      e_phase_dmem:      phase_words = cur_cfg.dmem_words;
      default:           phase_words = word_cnt_width_c'(1);
    endcase
  end

  assign w_last = (cur.w == phase_words - word_cnt_width_c'(1));
  assign x_last = (cur.tx == cur_cfg.dim_x - x_cord_width_c'(1));
  assign y_last = (cur.ty == cur_cfg.dim_y - y_cord_width_c'(1));

  // words innermost, then x, then y, then the phase
  always_comb begin
    pos_nxt = cur;
    if (cur_active) begin
      if (!w_last) begin
        pos_nxt.w = cur.w + 1'b1;
      end else begin
        pos_nxt.w = '0;
        if (!x_last) begin
          pos_nxt.tx = cur.tx + 1'b1;
        end else begin
          pos_nxt.tx = '0;
          if (!y_last) begin
            pos_nxt.ty = cur.ty + 1'b1;
          end else begin
            pos_nxt.ty    = '0;
            pos_nxt.phase = phase_after(cur.phase, cur_cfg);
          end
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // packet build and image fetch
  // ------------------------------------------------------------------------
  always_comb begin
    fetch_nxt.pkt.op         = e_packet_op_remote_store;
    fetch_nxt.pkt.x_cord     = cur_cfg.org_x + cur.tx;
    fetch_nxt.pkt.y_cord     = cur_cfg.org_y + cur.ty;
    fetch_nxt.pkt.src_x_cord = my_x_i;
    fetch_nxt.pkt.src_y_cord = my_y_i;
    fetch_nxt.pkt.addr       = unfreeze_addr_c;  // unfreeze: store zero to the CSR base
    fetch_nxt.pkt.payload    = '0;
    fetch_nxt.use_img        = 1'b0;
    img_raddr_o              = img_aw_lp'(cur.w);
    case (cur.phase)
      e_phase_group_cfg: begin
        if (cur.w == '0) begin
          fetch_nxt.pkt.addr    = csr_base_addr_c + csr_org_x_offs_c;
          fetch_nxt.pkt.payload = data_width_c'(cur_cfg.org_x);
        end else begin
          fetch_nxt.pkt.addr    = csr_base_addr_c + csr_org_y_offs_c;
          fetch_nxt.pkt.payload = data_width_c'(cur_cfg.org_y);
        end
      end
      e_phase_icache: begin
        fetch_nxt.pkt.addr = icache_sel_addr_c | addr_width_c'(cur.w);
        fetch_nxt.use_img  = 1'b1;
      end
      e_phase_dmem: begin
        fetch_nxt.pkt.addr = addr_width_c'(cur.w);
        fetch_nxt.use_img  = 1'b1;
        img_raddr_o        = img_aw_lp'(cur_cfg.dmem_base + cur.w);  // wraps in the image
      end
      default: ;
    endcase
  end

  // whole pipe moves when the output slot is free or being taken
  assign pipe_adv = !v_q || ready_i;
  assign img_re_o = pipe_adv && cur_active;

  always_comb begin
    out_nxt = fetch_q.pkt;
    if (fetch_q.use_img) begin
      out_nxt.payload = img_rdata_i;
    end
  end

  // last transfer, or nothing to send at all for an empty group
  assign done_set = busy_q && !done_q && (pos_q.phase == e_phase_idle)
                    && !fetch_v_q && (!v_q || ready_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pos_q     <= '{phase: e_phase_idle, tx: '0, ty: '0, w: '0};
      fetch_v_q <= 1'b0;
      v_q       <= 1'b0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      if (pipe_adv) begin
        pos_q     <= pos_nxt;
        fetch_v_q <= cur_active;
        v_q       <= fetch_v_q;
      end
      if (start_i) begin
        busy_q <= 1'b1;
      end else if (done_q) begin
        busy_q <= 1'b0;  // busy covers the done cycle
      end
      done_q <= done_set;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      cfg_q <= cfg_i;
    end
    if (pipe_adv) begin
      fetch_q <= fetch_nxt;
      out_q   <= out_nxt;
    end
  end

  assign packet_o = out_q;
  assign v_o      = v_q;
  assign busy_o   = busy_q;
  assign done_o   = done_q;

  a_stall_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    v_o && !ready_i |=> v_o && $stable(packet_o)
  ) else $error("packet changed or dropped while stalled");

  a_target_in_group: assert property (
    @(posedge clk_i) disable iff (reset_i)
    v_o |-> (x_cord_width_c'(packet_o.x_cord - cfg_q.org_x) < cfg_q.dim_x)
         && (y_cord_width_c'(packet_o.y_cord - cfg_q.org_y) < cfg_q.dim_y)
  ) else $error("packet target lies outside the tile group");

  a_done_not_with_valid: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(done_o && v_o)
  ) else $error("done raised while a packet is still pending");

endmodule

// File: src/spmd_loader_top.sv
`timescale 1ns/10ps

module spmd_loader_top
  import spmd_loader_pkg::*;
#(
  parameter int image_depth_p = 64
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      host_wr_v_i,
  input  host_wr_s                  host_wr_i,
  input  logic [x_cord_width_c-1:0] my_x_i,
  input  logic [y_cord_width_c-1:0] my_y_i,
  output load_packet_s              packet_o,
  output logic                      v_o,
  input  logic                      ready_i,
  output logic                      busy_o,
  output logic                      done_o
);

  localparam int img_aw_lp = $clog2(image_depth_p);

  load_cfg_s               cfg;
  logic                    start;
  logic                    img_we, img_re;
  logic [img_aw_lp-1:0]    img_waddr, img_raddr;
  logic [data_width_c-1:0] img_wdata, img_rdata;

  // ------------------------------------------------------------------------
  // host side
  // ------------------------------------------------------------------------
  loader_cfg_regs #(
    .image_depth_p(image_depth_p)
  ) u_cfg_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .host_wr_v_i(host_wr_v_i),
    .host_wr_i  (host_wr_i),
    .busy_i     (busy_o),      // locks host writes during a load
    .cfg_o      (cfg),
    .start_o    (start),
    .img_we_o   (img_we),
    .img_waddr_o(img_waddr),
    .img_wdata_o(img_wdata)
  );

  program_image_mem #(
    .image_depth_p(image_depth_p)
  ) u_image_mem (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .we_i   (img_we),
    .waddr_i(img_waddr),
    .wdata_i(img_wdata),
    .re_i   (img_re),
    .raddr_i(img_raddr),
    .rdata_o(img_rdata)
  );

  // network side
  spmd_loader_seq #(
    .image_depth_p(image_depth_p)
  ) u_seq (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .start_i    (start),
    .cfg_i      (cfg),
    .my_x_i     (my_x_i),
    .my_y_i     (my_y_i),
    .img_re_o   (img_re),
    .img_raddr_o(img_raddr),
    .img_rdata_i(img_rdata),
    .packet_o   (packet_o),
    .v_o        (v_o),
    .ready_i    (ready_i),
    .busy_o     (busy_o),
    .done_o     (done_o)
  );

endmodule

// File: tb/tb_spmd_loader.sv
`timescale 1ns/10ps

module tb_spmd_loader
  import spmd_loader_pkg::*;
();

  localparam int depth_c       = 64;
  // load one: 4 tiles of (3 + 5 + 6), load two: 3 tiles of (3 + 5 + 0)
  localparam int total_pkts_c  = 4 * (3 + 5 + 6) + 3 * (3 + 5 + 0);
  localparam int cycle_limit_c = 4 * total_pkts_c + 500;

  logic         clk = 1'b0;
  logic         reset;
  logic         host_wr_v;
  host_wr_s     host_wr;
  logic [2:0]   my_x, my_y;
  logic         ready;
  load_packet_s packet;
  logic         v, busy, done;

  load_cfg_s    ref_cfg;                 // model copy of the load registers
  logic [31:0]  ref_image [depth_c];     // model copy of the image
  load_packet_s exp_mem [256];           // expected packet queue
  load_packet_s exp_head;
  int           exp_wr = 0;
  int           exp_rd = 0;
  int           pkt_total = 0;           // packets owed by all starts so far
  int           starts_issued = 0;
  int           done_cnt = 0;
  int           cycle_cnt = 0;
  int           assert_errs = 0;
  int           final_errs = 0;
  logic [31:0]  rand_state = 32'd45134;

  spmd_loader_top #(
    .image_depth_p(depth_c)
  ) DUT (
    .clk_i      (clk),
    .reset_i    (reset),
    .host_wr_v_i(host_wr_v),
    .host_wr_i  (host_wr),
    .my_x_i     (my_x),
    .my_y_i     (my_y),
    .packet_o   (packet),
    .v_o        (v),
    .ready_i    (ready),
    .busy_o     (busy),
    .done_o     (done)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // every written word differs from zero and from its neighbours
  function automatic logic [31:0] image_word(input int addr, input logic [7:0] salt);
    return (32'h9e3779b9 * (addr + 1)) ^ {salt, 24'h0};
  endfunction

  task automatic note_fail(input string msg);
    assert_errs++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  // ------------------------------------------------------------------------
  // host port
  // ------------------------------------------------------------------------
  task automatic host_write(input logic to_image, input logic [7:0] addr,
                            input logic [31:0] data);
    @(posedge clk);
    host_wr_v <= 1'b1;
    host_wr   <= '{to_image: to_image, addr: addr, data: data};
  endtask

  task automatic host_idle();
    @(posedge clk);
    host_wr_v <= 1'b0;
  endtask

  task automatic write_image(input int addr, input logic [31:0] data);
    host_write(1'b1, 8'(addr), data);
    ref_image[addr] = data;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    host_write(1'b0, addr, data);
    case (addr)
      reg_org_x_c:        ref_cfg.org_x        = data[2:0];
      reg_org_y_c:        ref_cfg.org_y        = data[2:0];
      reg_dim_x_c:        ref_cfg.dim_x        = data[2:0];
      reg_dim_y_c:        ref_cfg.dim_y        = data[2:0];
      reg_icache_words_c: ref_cfg.icache_words = data[7:0];
      reg_dmem_words_c:   ref_cfg.dmem_words   = data[7:0];
      reg_dmem_base_c:    ref_cfg.dmem_base    = data[7:0];
      default: ;
    endcase
  endtask

  // ------------------------------------------------------------------------
  // reference model, phases outer, then tiles y by x, then words
  // ------------------------------------------------------------------------
  task automatic push_expected(input logic [2:0] x, input logic [2:0] y,
                               input logic [15:0] addr, input logic [31:0] payload);
    load_packet_s p;
    p.op         = e_packet_op_remote_store;
    p.addr       = addr;
    p.payload    = payload;
    p.x_cord     = x;
    p.y_cord     = y;
    p.src_x_cord = my_x;
    p.src_y_cord = my_y;
    exp_mem[exp_wr] = p;
    exp_wr = exp_wr + 1;
  endtask

  task automatic build_expected();
    logic [2:0] x, y;
    int         idx;
    for (int ph = 0; ph < 4; ph++) begin
      for (int ty = 0; ty < int'(ref_cfg.dim_y); ty++) begin
        for (int tx = 0; tx < int'(ref_cfg.dim_x); tx++) begin
          x = ref_cfg.org_x + 3'(tx);
          y = ref_cfg.org_y + 3'(ty);
          case (ph)
            0: begin
              push_expected(x, y, csr_base_addr_c + 16'd1, 32'(ref_cfg.org_x));
              push_expected(x, y, csr_base_addr_c + 16'd2, 32'(ref_cfg.org_y));
            end
            1: for (int i = 0; i < int'(ref_cfg.icache_words); i++) begin
              push_expected(x, y, 16'h4000 | 16'(i), ref_image[i]);
            end
            2: for (int j = 0; j < int'(ref_cfg.dmem_words); j++) begin
              idx = (int'(ref_cfg.dmem_base) + j) % depth_c;  // wraps in the image
              push_expected(x, y, 16'(j), ref_image[idx]);
            end
            default: push_expected(x, y, csr_base_addr_c, 32'h0);
          endcase
        end
      end
    end
  endtask

  task automatic start_load();
    build_expected();
    pkt_total = pkt_total + int'(ref_cfg.dim_x) * int'(ref_cfg.dim_y)
                * (3 + int'(ref_cfg.icache_words) + int'(ref_cfg.dmem_words));
    host_write(1'b0, reg_start_c, 32'h0);
    starts_issued <= starts_issued + 1;
    host_idle();
  endtask

  // ------------------------------------------------------------------------
  // network side, random ready and transfer bookkeeping
  // ------------------------------------------------------------------------
  assign exp_head = exp_mem[exp_rd];

  always @(posedge clk) begin
    rand_state = lcg_next(rand_state);
    ready <= rand_state[16];
  end

  always @(posedge clk) begin
    if (!reset && v && ready) exp_rd <= exp_rd + 1;
    if (!reset && done) done_cnt <= done_cnt + 1;
  end

  a_idle_before_start: assert property (@(posedge clk) disable iff (reset)
    starts_issued == 0 |-> !v && !busy && !done)
    else note_fail("outputs active before any start write");

  a_packet_matches: assert property (@(posedge clk) disable iff (reset)
    v && ready |-> exp_rd < exp_wr && packet == exp_head)
    else note_fail("transferred packet differs from the reference packet");

  a_stall_holds: assert property (@(posedge clk) disable iff (reset)
    v && !ready |=> v && $stable(packet))
    else note_fail("stalled packet changed or was withdrawn");

  a_valid_needs_busy: assert property (@(posedge clk) disable iff (reset)
    v |-> busy)
    else note_fail("packet valid while the loader is not busy");

  // one done per start, only after every owed packet went out
  a_done_complete: assert property (@(posedge clk) disable iff (reset)
    done |-> busy && exp_rd == exp_wr && exp_rd == pkt_total
             && starts_issued == done_cnt + 1)
    else note_fail("done pulse with a wrong packet count or without a start");

  a_idle_after_done: assert property (@(posedge clk) disable iff (reset)
    done |=> !busy && !v && !done)
    else note_fail("loader not idle in the cycle after done");

  // ------------------------------------------------------------------------
  // run limit
  // ------------------------------------------------------------------------
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit_c) begin
      $display("timeout: the loader did not finish within %0d cycles", cycle_limit_c);
      $display("errors: %0d assertion, %0d end of run", assert_errs, final_errs);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    reset     = 1'b1;
    host_wr_v = 1'b0;
    host_wr   = '0;
    my_x      = 3'd5;
    my_y      = 3'd6;
    ready     = 1'b0;
    ref_cfg   = '0;
    for (int i = 0; i < depth_c; i++) ref_image[i] = 32'h0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (5) @(posedge clk);  // idle outputs checked here

    // load one, words 4 and 63 stay unwritten
    for (int i = 0; i < 4; i++) write_image(i, image_word(i, 8'h11));
    for (int i = 60; i < 63; i++) write_image(i, image_word(i, 8'h11));
    write_reg(reg_org_x_c, 32'd1);
    write_reg(reg_org_y_c, 32'd2);
    write_reg(reg_dim_x_c, 32'd2);
    write_reg(reg_dim_y_c, 32'd2);
    write_reg(reg_icache_words_c, 32'd5);
    write_reg(reg_dmem_words_c, 32'd6);
    write_reg(reg_dmem_base_c, 32'd60);
    start_load();

    // all of these land while busy and must be dropped
    while (!busy) @(posedge clk);
    host_write(1'b0, reg_dim_x_c, 32'd3);
    host_write(1'b0, reg_icache_words_c, 32'd9);
    host_write(1'b1, 8'd4, 32'hdeadbeef);
    host_write(1'b0, reg_start_c, 32'h0);
    host_idle();
    while (done_cnt < 1) @(posedge clk);
    repeat (3) @(posedge clk);

    // load two, new source and image, no dmem phase
    my_x <= 3'd2;
    my_y <= 3'd7;
    for (int i = 0; i < 3; i++) write_image(i, image_word(i, 8'h22));
    write_reg(reg_org_x_c, 32'd4);
    write_reg(reg_org_y_c, 32'd0);
    write_reg(reg_dim_x_c, 32'd1);
    write_reg(reg_dim_y_c, 32'd3);
    // icache_words stays 5 from load one, word 4 must still read as zero
    write_reg(reg_dmem_words_c, 32'd0);
    start_load();
    while (done_cnt < 2) @(posedge clk);
    repeat (5) @(posedge clk);

    if (exp_rd != exp_wr || exp_wr != total_pkts_c) begin
      final_errs++;
      $display("[FAIL] %0t: %0d of %0d packets transferred", $time, exp_rd, exp_wr);
    end
    if (done_cnt != 2) begin
      final_errs++;
      $display("[FAIL] %0t: %0d done pulses seen for two loads", $time, done_cnt);
    end
    $display("errors: %0d assertion, %0d end of run", assert_errs, final_errs);
    if (assert_errs == 0 && final_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: tb.f
src/spmd_loader_pkg.sv
src/loader_cfg_regs.sv
src/program_image_mem.sv
src/spmd_loader_seq.sv
src/spmd_loader_top.sv
tb/tb_spmd_loader.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_spmd_loader -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
# a crashed or stopped run counts as a failure
./obj_dir/sim_tb > sim.log 2>&1 || echo "Verification failed" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
